// ==== all.f ====
design/cache_pkg.sv
design/plru_tree.sv
design/cache_ways.sv
design/cache_ctrl.sv
design/cache_top.sv
verification/mem_model.sv
verification/cache_asserts.sv
verification/cache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f all.f --top-module cache_tb -o cache_sim \
    && ./obj_dir/cache_sim | tee sim.log \
    || echo "Build or simulation ended with an error"

grep -qx "Simulation passed" sim.log && echo "PASS" && exit 0 \
    || { echo "FAIL"; exit 1; }

// ==== verification/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb import cache_pkg::*; ();

    localparam logic [31:0] seed         = 32'hae2c317e;
    localparam int          num_random   = 400;
    localparam int          num_requests = num_random + 60;
    localparam int          worst_cycles = 40;  // Write-back, fill, latency and stalls

    typedef struct packed {
        logic        write;
        word_t       data;
    } pending_t;

    logic        clk;
    logic        reset_n;
    logic        req_valid;
    cpu_req_t    req;
    logic        req_ready;
    logic        rsp_valid;
    word_t       rsp_data;
    logic        mem_req_valid;
    mem_req_t    mem_req;
    logic        mem_req_ready;
    logic        mem_rsp_valid;
    line_t       mem_rsp_data;
    int unsigned mem_latency;
    logic        mem_stall;

    pending_t    pending[$];
    word_t       shadow [logic [29:0]];  // Last written word per word address
    int          cycle = 0;
    int          rd_count = 0;
    int          wb_count = 0;
    int          latency_seen;
    logic [31:0] last_rd;
    mem_req_t    last_wb;
    logic [31:0] lat_state = seed;
    logic [31:0] stim_state = seed;

    cache_top dut0 (.*);

    mem_model mem0 (
        .clk(clk), .reset_n(reset_n),
        .mem_req_valid(mem_req_valid), .mem_req(mem_req), .mem_req_ready(mem_req_ready),
        .mem_rsp_valid(mem_rsp_valid), .mem_rsp_data(mem_rsp_data),
        .latency(mem_latency), .stall(mem_stall)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] make_addr(input int tag, input int index, input int word);
        cache_addr_t a;
        a.word       = '0;
        a.f.tag      = tag_t'(tag);
        a.f.index    = index_t'(index);
        a.f.word_sel = 2'(word);
        return a.word;
    endfunction

    // Reference model of a transparent cache
    function automatic word_t expected_word(input logic [31:0] addr);
        if (shadow.exists(addr[31:2])) begin
            return shadow[addr[31:2]];
        end
        return mem0.pattern_word({addr[31:2], 2'b00});
    endfunction

    function automatic logic [2:0] plru_next(input logic [2:0] bits, input int way);
        case (way)
            0: return {2'b11, bits[0]};
            1: return {2'b10, bits[0]};
            2: return {1'b0, bits[1], 1'b1};
            default: return {1'b0, bits[1], 1'b0};
        endcase
    endfunction

    function automatic int plru_pick(input logic [2:0] bits);
        if (bits[2]) begin
            return bits[0] ? 3 : 2;
        end
        return bits[1] ? 1 : 0;
    endfunction

    task automatic check(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // One request and its response
    task automatic access(input logic write, input logic [31:0] addr, input word_t data);
        pending_t p;
        int       start;
        while (!req_ready) @(negedge clk);
        p.write = write;
        p.data  = write ? data : expected_word(addr);
        if (write) begin
            shadow[addr[31:2]] = data;
        end
        pending.push_back(p);
        req_valid     = 1'b1;
        req.write     = write;
        req.addr.word = addr;
        req.data      = data;
        start         = cycle + 1;  // Accepting edge
        @(negedge clk);
        req_valid = 1'b0;
        while (!rsp_valid) @(negedge clk);
        latency_seen = cycle - start;
        @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Fresh latency and stall, then log the handshake of the next edge
    always @(negedge clk) begin
        lat_state   = xorshift(lat_state);
        mem_latency = 32'(lat_state[2:0]);
        mem_stall   = (lat_state[5:4] == 2'b00);
        if (reset_n && mem_req_valid && !mem_stall && !mem0.busy) begin
            if (mem_req.write) begin
                wb_count++;
                last_wb = mem_req;
            end else begin
                rd_count++;
                last_rd = mem_req.addr.word;
            end
        end
    end

    always @(negedge clk) begin
        pending_t p;
        if (rsp_valid) begin
            if (pending.size() == 0) begin
                $display("A response arrived with no request outstanding");
                $display("Simulation failed");
                $fatal(1, "Unexpected response");
            end else begin
                p = pending.pop_front();
                if (!p.write) begin
                    check("rsp_data", rsp_data, p.data);
                end
            end
        end
    end

    initial begin
        #((10 + num_requests * worst_cycles) * 20);
        $display("Timeout, the requests did not complete in the expected time");
        $display("Simulation failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        logic [31:0] a;
        word_t       exp_line [4];
        logic [2:0]  bits;
        int          victim;
        int          rd0;
        int          wb0;
        int          order [4];
        reset_n     = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        mem_latency = 0;
        mem_stall   = 1'b0;
        repeat (10) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);

        a   = make_addr(5, 3, 1);  // Read miss fill
        rd0 = rd_count;
        access(1'b0, a, '0);
        check("mem read count", rd_count - rd0, 1);
        check("mem_req.addr", last_rd, {a[31:4], 4'b0});

        wb0 = wb_count;  // Read hit
        access(1'b0, make_addr(5, 3, 2), '0);
        check("hit latency", latency_seen, 2);
        check("mem request count", rd_count - rd0 + wb_count - wb0, 1);

        access(1'b1, make_addr(5, 3, 2), 32'hcafe0001);
        check("mem request count", rd_count - rd0 + wb_count - wb0, 1);
        for (int w = 0; w < 4; w++) begin
            access(1'b0, make_addr(5, 3, w), '0);
        end
        access(1'b1, make_addr(9, 4, 1), 32'hbeef0002);
        for (int w = 0; w < 4; w++) begin
            access(1'b0, make_addr(9, 4, w), '0);
        end

        bits = '0;  // Dirty write-back
        for (int w = 0; w < 4; w++) begin
            access(1'b1, make_addr(100 + w, 20, 1), 32'h10000000 + w);
            bits = plru_next(bits, w);
        end
        victim = plru_pick(bits);
        a      = make_addr(100 + victim, 20, 0);
        for (int w = 0; w < 4; w++) begin
            exp_line[w] = expected_word(a + 32'(4 * w));
        end
        wb0 = wb_count;
        access(1'b1, make_addr(104, 20, 3), 32'h20000004);
        check("write-back count", wb_count - wb0, 1);
        check("mem_req.addr", last_wb.addr.word, a);
        for (int w = 0; w < 4; w++) begin
            check("mem_req.line", last_wb.line[w], exp_line[w]);
        end
        rd0 = rd_count;
        access(1'b0, make_addr(100 + victim, 20, 1), '0);
        check("mem read count", rd_count - rd0, 1);

        bits  = '0;  // Pseudo-LRU order
        order = '{2, 0, 3, 1};
        for (int w = 0; w < 4; w++) begin
            access(1'b0, make_addr(200 + w, 40, 0), '0);
            bits = plru_next(bits, w);
        end
        for (int i = 0; i < 4; i++) begin
            access(1'b0, make_addr(200 + order[i], 40, 1), '0);
            bits = plru_next(bits, order[i]);
        end
        victim = plru_pick(bits);
        wb0    = wb_count;
        access(1'b0, make_addr(204, 40, 2), '0);
        check("write-back count", wb_count - wb0, 0);
        for (int w = 0; w < 4; w++) begin
            if (w != victim) begin
                rd0 = rd_count;
                access(1'b0, make_addr(200 + w, 40, 3), '0);
                check("mem read count", rd_count - rd0, 0);
            end
        end
        rd0 = rd_count;
        access(1'b0, make_addr(200 + victim, 40, 3), '0);
        check("mem read count", rd_count - rd0, 1);

        for (int i = 0; i < num_random; i++) begin
            stim_state = xorshift(stim_state);
            a = make_addr(int'(stim_state[10:8]) % 6, 60 + int'(stim_state[13:12]) % 3,
                          int'(stim_state[15:14]));
            access(stim_state[31], a, xorshift(stim_state ^ 32'h5555aaaa));
        end

        if (pending.size() != 0) begin
            $display("%0d responses never arrived", pending.size());
            $display("Simulation failed");
            $fatal(1, "Missing responses");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

// ==== verification/cache_asserts.sv ====
`timescale 1ns/1ps

module cache_asserts import cache_pkg::*; (
    input logic     clk,
    input logic     reset_n,
    input logic     req_ready,
    input logic     rsp_valid,
    input logic     mem_req_valid,
    input logic     mem_req_ready,
    input mem_req_t mem_req
);

    // Held until the memory takes it
    property mem_req_held;
        @(posedge clk) disable iff (!reset_n)
            mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req);
    endproperty

    property rsp_one_cycle;
        @(posedge clk) disable iff (!reset_n) rsp_valid |=> !rsp_valid;
    endproperty

    property mem_idle_when_ready;
        @(posedge clk) disable iff (!reset_n) !(mem_req_valid && req_ready);
    endproperty

    mem_req_held_a: assert property (mem_req_held)
        else $error("mem_req changed before mem_req_ready");
    rsp_one_cycle_a: assert property (rsp_one_cycle)
        else $error("rsp_valid high for more than one cycle");
    mem_idle_when_ready_a: assert property (mem_idle_when_ready)
        else $error("mem_req_valid high while req_ready is high");

endmodule

bind cache_ctrl cache_asserts asserts0 (.*);

// ==== verification/mem_model.sv ====
`timescale 1ns/1ps

module mem_model import cache_pkg::*; (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        mem_req_valid,
    input  mem_req_t    mem_req,
    output logic        mem_req_ready,
    output logic        mem_rsp_valid,
    output line_t       mem_rsp_data,
    input  int unsigned latency,
    input  logic        stall
);

    line_t       lines [logic [31:0]];  // Only lines that were written back
    logic        busy = 1'b0;
    logic        rsp_pulse = 1'b0;
    line_t       rsp_line = '0;
    int unsigned count;
    logic [31:0] rd_addr;

    // Odd multiplier, so every address bit matters
    function automatic word_t pattern_word(input logic [31:0] addr);
        return (addr * 32'h9e3779b1) ^ 32'h5ac30f1e;
    endfunction

    function automatic line_t read_line(input logic [31:0] addr);
        line_t l;
        if (lines.exists(addr)) begin
            return lines[addr];
        end
        for (int w = 0; w < 4; w++) begin
            l[w] = pattern_word(addr + 32'(4 * w));
        end
        return l;
    endfunction

    assign mem_req_ready = !busy && !stall;
    assign mem_rsp_valid = rsp_pulse;
    assign mem_rsp_data  = rsp_line;

    always @(posedge clk) begin
        if (!reset_n) begin
            busy      <= 1'b0;
            count     <= 0;
            rsp_pulse <= 1'b0;
        end else begin
            rsp_pulse <= 1'b0;
            if (mem_req_valid && mem_req_ready) begin
                if (mem_req.write) begin
                    lines[mem_req.addr.word] = mem_req.line;  // No response
                end else begin
                    busy    <= 1'b1;
                    count   <= latency;
                    rd_addr <= mem_req.addr.word;
                end
            end else if (busy) begin
                if (count == 0) begin
                    busy      <= 1'b0;
                    rsp_pulse <= 1'b1;
                    rsp_line  <= read_line(rd_addr);
                end else begin
                    count <= count - 1;
                end
            end
        end
    end

endmodule

// ==== design/cache_top.sv ====
`timescale 1ns/1ps

module cache_top import cache_pkg::*; (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     req_valid,
    input  cpu_req_t req,
    output logic     req_ready,
    output logic     rsp_valid,
    output word_t    rsp_data,
    output logic     mem_req_valid,
    output mem_req_t mem_req,
    input  logic     mem_req_ready,
    input  logic     mem_rsp_valid,
    input  line_t    mem_rsp_data
);

    index_t                     rd_index;
    way_info_t [num_ways-1:0]   way_info;
    line_t     [num_ways-1:0]   way_line;
    logic                       wr_en;
    way_t                       wr_way;
    index_t                     wr_index;
    line_t                      wr_line;
    tag_t                       wr_tag;
    logic                       wr_dirty;
    way_t                       plru_victim;
    logic                       plru_touch;
    way_t                       plru_way;

    cache_ctrl ctrl0 (
        .clk(clk), .reset_n(reset_n),
        .req_valid(req_valid), .req(req), .req_ready(req_ready),
        .rsp_valid(rsp_valid), .rsp_data(rsp_data),
        .mem_req_valid(mem_req_valid), .mem_req(mem_req), .mem_req_ready(mem_req_ready),
        .mem_rsp_valid(mem_rsp_valid), .mem_rsp_data(mem_rsp_data),
        .rd_index(rd_index), .way_info(way_info), .way_line(way_line),
        .wr_en(wr_en), .wr_way(wr_way), .wr_index(wr_index),
        .wr_line(wr_line), .wr_tag(wr_tag), .wr_dirty(wr_dirty),
        .plru_victim(plru_victim), .plru_touch(plru_touch), .plru_way(plru_way)
    );

    cache_ways ways0 (
        .clk(clk), .reset_n(reset_n),
        .rd_index(rd_index), .way_info(way_info), .way_line(way_line),
        .wr_en(wr_en), .wr_way(wr_way), .wr_index(wr_index),
        .wr_line(wr_line), .wr_tag(wr_tag), .wr_dirty(wr_dirty)
    );

    plru_tree plru0 (
        .clk(clk), .reset_n(reset_n),
        .index(rd_index), .victim(plru_victim),
        .touch(plru_touch), .touch_way(plru_way)
    );

endmodule

// ==== design/cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     req_valid,
    input  cpu_req_t                 req,
    output logic                     req_ready,
    output logic                     rsp_valid,
    output word_t                    rsp_data,
    output logic                     mem_req_valid,
    output mem_req_t                 mem_req,
    input  logic                     mem_req_ready,
    input  logic                     mem_rsp_valid,
    input  line_t                    mem_rsp_data,
    output index_t                   rd_index,
    input  way_info_t [num_ways-1:0] way_info,
    input  line_t     [num_ways-1:0] way_line,
    output logic                     wr_en,
    output way_t                     wr_way,
    output index_t                   wr_index,
    output line_t                    wr_line,
    output tag_t                     wr_tag,
    output logic                     wr_dirty,
    input  way_t                     plru_victim,
    output logic                     plru_touch,
    output way_t                     plru_way
);

    typedef enum logic [2:0] {
        s_idle,
        s_read,        // Set lookup in flight
        s_compare,
        s_write_back,
        s_fill_req,
        s_fill_wait
    } state_t;

    state_t              state_q;
    cpu_req_t            req_q;
    way_t                victim_q;
    logic [num_ways-1:0] hit_mask;
    logic                hit;
    way_t                hit_way;
    way_t                alloc_way;
    logic                victim_dirty;
    way_t                sel_way;
    line_t               base_line;
    line_t               merged_line;
    logic                done;
    cache_addr_t         fill_addr;
    cache_addr_t         wb_addr;
    mem_req_t            fill_req;
    mem_req_t            wb_req;

    assign rd_index = req_q.addr.f.index;

    // Tag compare against the registered set
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            hit_mask[w] = way_info[w].valid && (way_info[w].tag == req_q.addr.f.tag);
            if (hit_mask[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit = |hit_mask;

    // First invalid way wins over the PLRU choice
    always_comb begin
        alloc_way = plru_victim;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (!way_info[w].valid) begin
                alloc_way = way_t'(w);
            end
        end
    end

    assign victim_dirty = way_info[alloc_way].valid && way_info[alloc_way].dirty;

    assign sel_way   = (state_q == s_compare) ? hit_way : victim_q;
    assign base_line = (state_q == s_compare) ? way_line[sel_way] : mem_rsp_data;

    always_comb begin
        merged_line = base_line;
        if (req_q.write) begin
            merged_line[req_q.addr.f.word_sel] = req_q.data;
        end
    end

    assign done = ((state_q == s_compare) && hit) || ((state_q == s_fill_wait) && mem_rsp_valid);

    // Read hits leave the line alone
    assign wr_en    = done && (req_q.write || (state_q == s_fill_wait));
    assign wr_way   = sel_way;
    assign wr_index = req_q.addr.f.index;
    assign wr_line  = merged_line;
    assign wr_tag   = req_q.addr.f.tag;
    assign wr_dirty = req_q.write;

    assign plru_touch = done;
    assign plru_way   = sel_way;

    always_comb begin
        fill_addr            = req_q.addr;
        fill_addr.f.word_sel = '0;
        fill_addr.f.byte_sel = '0;
        wb_addr              = fill_addr;
        wb_addr.f.tag        = way_info[alloc_way].tag;  // Victim's old line
    end

    always_comb begin
        fill_req.write = 1'b0;
        fill_req.addr  = fill_addr;
        fill_req.line  = '0;
        wb_req.write   = 1'b1;
        wb_req.addr    = wb_addr;
        wb_req.line    = way_line[alloc_way];
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state_q       <= s_idle;
            req_ready     <= 1'b1;
            rsp_valid     <= 1'b0;
            mem_req_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (state_q)
                s_idle: begin
                    if (req_valid && req_ready) begin
                        req_ready <= 1'b0;
                        state_q   <= s_read;
                    end
                end
                s_read: begin
                    state_q <= s_compare;
                end
                s_compare: begin
                    if (hit) begin
                        rsp_valid <= 1'b1;
                        req_ready <= 1'b1;
                        state_q   <= s_idle;
                    end else begin
                        mem_req_valid <= 1'b1;
                        state_q       <= victim_dirty ? s_write_back : s_fill_req;
                    end
                end
                s_write_back: begin
                    if (mem_req_ready) begin
                        state_q <= s_fill_req;  // Valid stays up for the fill
                    end
                end
                s_fill_req: begin
                    if (mem_req_ready) begin
                        mem_req_valid <= 1'b0;
                        state_q       <= s_fill_wait;
                    end
                end
                s_fill_wait: begin
                    if (mem_rsp_valid) begin
                        rsp_valid <= 1'b1;
                        req_ready <= 1'b1;
                        state_q   <= s_idle;
                    end
                end
                default: begin
                    state_q <= s_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == s_idle && req_valid) begin
            req_q <= req;
        end
        if (state_q == s_compare) begin
            victim_q <= alloc_way;
            mem_req  <= victim_dirty ? wb_req : fill_req;
        end
        if (state_q == s_write_back && mem_req_ready) begin
            mem_req <= fill_req;
        end
        if (done) begin
            rsp_data <= merged_line[req_q.addr.f.word_sel];
        end
    end

endmodule

// ==== design/cache_ways.sv ====
`timescale 1ns/1ps

module cache_ways import cache_pkg::*; (
    input  logic                     clk,
    input  logic                     reset_n,
    input  index_t                   rd_index,
    output way_info_t [num_ways-1:0] way_info,
    output line_t     [num_ways-1:0] way_line,
    input  logic                     wr_en,
    input  way_t                     wr_way,
    input  index_t                   wr_index,
    input  line_t                    wr_line,
    input  tag_t                     wr_tag,
    input  logic                     wr_dirty
);

    logic [num_sets-1:0][num_ways-1:0] valid_q;
    logic [num_sets-1:0][num_ways-1:0] dirty_q;
    logic [num_ways-1:0]               valid_rd;
    logic [num_ways-1:0]               dirty_rd;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_index][wr_way] <= 1'b1;
            dirty_q[wr_index][wr_way] <= wr_dirty;
        end
    end

    always_ff @(posedge clk) begin
        valid_rd <= valid_q[rd_index];
        dirty_rd <= dirty_q[rd_index];
    end

    // One tag RAM and one line RAM per way
    for (genvar w = 0; w < num_ways; w++) begin : g_way
        tag_t  tag_mem  [num_sets];
        line_t line_mem [num_sets];
        tag_t  tag_rd;
        line_t line_rd;

        always_ff @(posedge clk) begin
            if (wr_en && (wr_way == way_t'(w))) begin
                tag_mem[wr_index]  <= wr_tag;
                line_mem[wr_index] <= wr_line;
            end
            tag_rd  <= tag_mem[rd_index];   // Read before write on a collision
            line_rd <= line_mem[rd_index];
        end

        assign way_info[w].valid = valid_rd[w];
        assign way_info[w].dirty = dirty_rd[w];
        assign way_info[w].tag   = tag_rd;
        assign way_line[w]       = line_rd;
    end

endmodule

// ==== design/plru_tree.sv ====
`timescale 1ns/1ps

module plru_tree import cache_pkg::*; (
    input  logic   clk,
    input  logic   reset_n,
    input  index_t index,
    output way_t   victim,
    input  logic   touch,
    input  way_t   touch_way
);

    // b2 root, b1 ways 0/1, b0 ways 2/3
    logic [num_sets-1:0][2:0] bits_q;
    logic [2:0]               cur;

    assign cur = bits_q[index];

    always_comb begin
        if (cur[2]) begin
            victim = cur[0] ? 2'd3 : 2'd2;
        end else begin
            victim = cur[1] ? 2'd1 : 2'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            bits_q <= '0;
        end else if (touch) begin
            case (touch_way)
                2'd0: bits_q[index][2:1] <= 2'b11;
                2'd1: bits_q[index][2:1] <= 2'b10;
                2'd2: bits_q[index]      <= {1'b0, cur[1], 1'b1};  // b1 kept
                2'd3: bits_q[index]      <= {1'b0, cur[1], 1'b0};
                default: bits_q[index]   <= cur;
            endcase
        end
    end

endmodule

// ==== design/cache_pkg.sv ====
package cache_pkg;

    localparam int num_ways       = 4;
    localparam int num_sets       = 128;
    localparam int index_width    = 7;
    localparam int word_sel_width = 2;
    localparam int byte_sel_width = 2;
    localparam int tag_width      = 32 - index_width - word_sel_width - byte_sel_width;
    localparam int line_width     = 128;

    typedef logic [31:0] word_t;
    typedef logic [line_width/32-1:0][31:0] line_t;  // Word 0 in the low bits
    typedef logic [tag_width-1:0] tag_t;
    typedef logic [index_width-1:0] index_t;
    typedef logic [1:0] way_t;

    typedef struct packed {
        tag_t                      tag;
        index_t                    index;
        logic [word_sel_width-1:0] word_sel;
        logic [byte_sel_width-1:0] byte_sel;
    } addr_fields_t;

    // Byte address, seen as one word or split into cache fields
    typedef union packed {
        logic [31:0]  word;
        addr_fields_t f;
    } cache_addr_t;

    typedef struct packed {
        logic        write;
        cache_addr_t addr;
        word_t       data;
    } cpu_req_t;

    typedef struct packed {
        logic        write;
        cache_addr_t addr;  // Line aligned
        line_t       line;
    } mem_req_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } way_info_t;

endpackage
